//--- logic/rrPkg.sv
/*
 * Shared sizes, packet structs and port structs for the register-read stage.
 */

package rrPkg;

  // ==========================================================================
  // Sizes
  // ==========================================================================

  localparam int NUM_PHYS_REGS   = 64;
  localparam int PHYS_TAG_W      = $clog2(NUM_PHYS_REGS);
  localparam int NUM_ARCH_REGS   = 32;  // Registers holding committed state after reset.
  localparam int DATA_W          = 32;
  localparam int NUM_CHECKPOINTS = 8;
  localparam int CKPT_ID_W       = $clog2(NUM_CHECKPOINTS);
  localparam int NUM_WB_PORTS    = 2;
  localparam int PAYLOAD_W       = 48;

  // Ready pattern loaded on reset and on an exception.
  localparam logic [NUM_PHYS_REGS-1:0] READY_INIT =
    {{(NUM_PHYS_REGS - NUM_ARCH_REGS){1'b0}}, {NUM_ARCH_REGS{1'b1}}};

  // ==========================================================================
  // Basic types
  // ==========================================================================

  typedef logic [PHYS_TAG_W-1:0]      physTag_t;
  typedef logic [DATA_W-1:0]          regData_t;
  typedef logic [NUM_CHECKPOINTS-1:0] branchMask_t;

  // ==========================================================================
  // Instruction packets
  // ==========================================================================

  // Issue queue index, LSQ and active list ids, immediate, opcode and PCs all
  // ride in the payload. This stage never looks inside it.
  typedef struct packed {
    branchMask_t           branchMask;
    physTag_t              src1Tag;
    physTag_t              src2Tag;
    logic [PAYLOAD_W-1:0]  payload;
  } issuePacket_t;

  typedef struct packed {
    issuePacket_t inst;
    regData_t     src1Data;
    regData_t     src2Data;
  } readPacket_t;

  // ==========================================================================
  // Side-band ports
  // ==========================================================================

  typedef struct packed {
    logic     valid;
    physTag_t tag;
    regData_t data;
  } wbPort_t;

  typedef struct packed {
    logic     valid;
    physTag_t tag;
  } unmapPort_t;

  typedef struct packed {
    logic                 valid;
    logic                 mispredict;
    logic [CKPT_ID_W-1:0] ckptId;  // Checkpoint of the resolved branch.
  } branchResolve_t;

endpackage

//--- logic/physRegFile.sv
/*
 * Physical register file with two write ports and two combinational reads.
 */

`timescale 1ns/1ps

module physRegFile (
  input  logic             clk,
  input  logic             arstN_i,
  input  rrPkg::wbPort_t   wbPorts_i [rrPkg::NUM_WB_PORTS],
  input  logic             recover_i,
  input  rrPkg::physTag_t  rdTag1_i,
  input  rrPkg::physTag_t  rdTag2_i,
  output rrPkg::regData_t  rdData1_o,
  output rrPkg::regData_t  rdData2_o
);

  import rrPkg::*;

  regData_t regs [NUM_PHYS_REGS];
  logic     writeEn;

  // Writebacks are dropped while recovering and while reset is held.
  assign writeEn = arstN_i & ~recover_i;

  // ==========================================================================
  // Write ports
  // ==========================================================================

  // Ports are visited from the highest down, so port 0 wins when two ports
  // hit the same tag. This agrees with the bypass priority.
  always_ff @(posedge clk) begin
    for (int p = NUM_WB_PORTS - 1; p >= 0; p--) begin
      if (writeEn && wbPorts_i[p].valid) begin
        regs[wbPorts_i[p].tag] <= wbPorts_i[p].data;
      end
    end
  end

  // ==========================================================================
  // Read ports
  // ==========================================================================

  assign rdData1_o = regs[rdTag1_i];
  assign rdData2_o = regs[rdTag2_i];

endmodule

//--- logic/operandBypass.sv
/*
 * Operand selection between register file data and same-cycle writebacks.
 */

`timescale 1ns/1ps

module operandBypass (
  input  rrPkg::issuePacket_t packet_i,
  input  rrPkg::regData_t     fileData1_i,
  input  rrPkg::regData_t     fileData2_i,
  input  rrPkg::wbPort_t      wbPorts_i [rrPkg::NUM_WB_PORTS],
  output rrPkg::readPacket_t  packet_o
);

  import rrPkg::*;

  // Returns the forwarded value for a tag, or the stored value when no valid
  // writeback matches. The lowest numbered matching port has priority.
  function automatic regData_t pickOperand(
    input physTag_t tag,
    input regData_t fileData,
    input wbPort_t  ports [NUM_WB_PORTS]
  );
    regData_t data;
    data = fileData;
    for (int p = NUM_WB_PORTS - 1; p >= 0; p--) begin
      if (ports[p].valid && (ports[p].tag == tag)) begin
        data = ports[p].data;
      end
    end
    return data;
  endfunction

  // Forwarding does not look at recover_i, the file write does.
  always_comb begin
    packet_o.inst     = packet_i;
    packet_o.src1Data = pickOperand(packet_i.src1Tag, fileData1_i, wbPorts_i);
    packet_o.src2Data = pickOperand(packet_i.src2Tag, fileData2_i, wbPorts_i);
  end

endmodule

//--- logic/squashBuffer.sv
/*
 * Two-entry skid buffer with valid/ready on both sides.
 * Packets hit by a resolved mispredict are dropped on entry or from storage.
 */

`timescale 1ns/1ps

module squashBuffer (
  input  logic                  clk,
  input  logic                  arstN_i,
  input  logic                  inValid_i,
  input  rrPkg::readPacket_t    inPacket_i,
  output logic                  inReady_o,
  output logic                  outValid_o,
  output rrPkg::readPacket_t    outPacket_o,
  input  logic                  outReady_i,
  input  rrPkg::branchResolve_t branch_i
);

  import rrPkg::*;

  // Entry 0 is always the oldest packet.
  logic        entryValid [2];
  readPacket_t entryData  [2];
  logic        nextValid  [2];
  readPacket_t nextData   [2];

  logic       killIn;
  logic       kill [2];
  logic       pop;
  logic       push;
  logic       keep0;
  logic       keep1;
  logic       fill;

  function automatic logic isSquashed(
    input branchMask_t    mask,
    input branchResolve_t br
  );
    return br.valid && br.mispredict && mask[br.ckptId];
  endfunction

  // ==========================================================================
  // Squash and handshake
  // ==========================================================================

  assign killIn  = isSquashed(inPacket_i.inst.branchMask, branch_i);
  assign kill[0] = entryValid[0] && isSquashed(entryData[0].inst.branchMask, branch_i);
  assign kill[1] = entryValid[1] && isSquashed(entryData[1].inst.branchMask, branch_i);

  assign inReady_o   = ~entryValid[1];  // Room is left unless the second entry is taken.
  assign outValid_o  = entryValid[0] & ~kill[0];
  assign outPacket_o = entryData[0];

  assign pop   = outValid_o & outReady_i;
  assign push  = inValid_i & inReady_o & ~killIn;
  assign keep0 = entryValid[0] & ~kill[0] & ~pop;
  assign keep1 = entryValid[1] & ~kill[1];

  // ==========================================================================
  // Next state
  // ==========================================================================

  // Survivors shift toward entry 0 and the new packet lands behind them.
  always_comb begin
    nextValid[0] = 1'b0;
    nextValid[1] = 1'b0;
    nextData[0]  = entryData[0];
    nextData[1]  = entryData[1];
    fill         = 1'b0;
    if (keep0) begin
      nextValid[0] = 1'b1;
      fill         = 1'b1;
    end
    if (keep1) begin
      nextValid[fill] = 1'b1;
      nextData[fill]  = entryData[1];
    end
    // A push needs entry 1 free, so entry 1 was not kept here.
    if (push) begin
      nextValid[fill] = 1'b1;
      nextData[fill]  = inPacket_i;
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      entryValid[0] <= 1'b0;
      entryValid[1] <= 1'b0;
    end else begin
      entryValid[0] <= nextValid[0];
      entryValid[1] <= nextValid[1];
    end
  end

  always_ff @(posedge clk) begin
    entryData[0] <= nextData[0];
    entryData[1] <= nextData[1];
  end

endmodule

//--- logic/readyScoreboard.sv
/*
 * Ready scoreboard with one bit per physical register.
 */

`timescale 1ns/1ps

module readyScoreboard (
  input  logic                            clk,
  input  logic                            arstN_i,
  input  logic                            exception_i,
  input  rrPkg::unmapPort_t               unmapPorts_i [rrPkg::NUM_WB_PORTS],
  input  rrPkg::wbPort_t                  wbPorts_i    [rrPkg::NUM_WB_PORTS],
  output logic [rrPkg::NUM_PHYS_REGS-1:0] phyRegRdy_o
);

  import rrPkg::*;

  logic [NUM_PHYS_REGS-1:0] readyBits;
  logic [NUM_PHYS_REGS-1:0] nextReady;

  // Clears are applied first, so a writeback to the same register wins.
  always_comb begin
    nextReady = readyBits;
    for (int p = 0; p < NUM_WB_PORTS; p++) begin
      if (unmapPorts_i[p].valid) begin
        nextReady[unmapPorts_i[p].tag] = 1'b0;
      end
    end
    for (int p = 0; p < NUM_WB_PORTS; p++) begin
      if (wbPorts_i[p].valid) begin
        nextReady[wbPorts_i[p].tag] = 1'b1;
      end
    end
  end

  // An exception rolls back to the architectural map.
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      readyBits <= READY_INIT;
    end else if (exception_i) begin
      readyBits <= READY_INIT;
    end else begin
      readyBits <= nextReady;
    end
  end

  assign phyRegRdy_o = readyBits;

endmodule

//--- logic/regReadStage.sv
/*
 * Register-read stage top level.
 * Operand fetch and bypass feed a squash-aware skid buffer toward execute.
 */

`timescale 1ns/1ps

module regReadStage (
  input  logic                            clk,
  input  logic                            arstN_i,
  // Issue side.
  input  logic                            issueValid_i,
  input  rrPkg::issuePacket_t             issuePacket_i,
  output logic                            issueReady_o,
  // Writeback, unmap and branch resolution.
  input  rrPkg::wbPort_t                  wbPorts_i    [rrPkg::NUM_WB_PORTS],
  input  rrPkg::unmapPort_t               unmapPorts_i [rrPkg::NUM_WB_PORTS],
  input  rrPkg::branchResolve_t           branch_i,
  input  logic                            recover_i,
  input  logic                            exception_i,
  // Execute side.
  output logic                            execValid_o,
  output rrPkg::readPacket_t              execPacket_o,
  input  logic                            execReady_i,
  output logic [rrPkg::NUM_PHYS_REGS-1:0] phyRegRdy_o
);

  import rrPkg::*;

  regData_t    fileData1;
  regData_t    fileData2;
  readPacket_t fetchedPacket;

  physRegFile u_physRegFile (
    .clk       (clk),
    .arstN_i   (arstN_i),
    .wbPorts_i (wbPorts_i),
    .recover_i (recover_i),
    .rdTag1_i  (issuePacket_i.src1Tag),
    .rdTag2_i  (issuePacket_i.src2Tag),
    .rdData1_o (fileData1),
    .rdData2_o (fileData2)
  );

  operandBypass u_operandBypass (
    .packet_i    (issuePacket_i),
    .fileData1_i (fileData1),
    .fileData2_i (fileData2),
    .wbPorts_i   (wbPorts_i),
    .packet_o    (fetchedPacket)
  );

  // Operands are captured here at acceptance.
  squashBuffer u_squashBuffer (
    .clk         (clk),
    .arstN_i     (arstN_i),
    .inValid_i   (issueValid_i),
    .inPacket_i  (fetchedPacket),
    .inReady_o   (issueReady_o),
    .outValid_o  (execValid_o),
    .outPacket_o (execPacket_o),
    .outReady_i  (execReady_i),
    .branch_i    (branch_i)
  );

  readyScoreboard u_readyScoreboard (
    .clk          (clk),
    .arstN_i      (arstN_i),
    .exception_i  (exception_i),
    .unmapPorts_i (unmapPorts_i),
    .wbPorts_i    (wbPorts_i),
    .phyRegRdy_o  (phyRegRdy_o)
  );

endmodule

//--- verification/regRead_props.sv
/*
 * Concurrent checks on the register-read stage, bound into its top level.
 */

`timescale 1ns/1ps

module regReadProps (
  input logic                            clk,
  input logic                            arstN_i,
  input logic                            issueReady_o,
  input logic                            execValid_o,
  input logic                            execReady_i,
  input rrPkg::readPacket_t              execPacket_o,
  input rrPkg::branchResolve_t           branch_i,
  input logic [rrPkg::NUM_PHYS_REGS-1:0] phyRegRdy_o
);

  import rrPkg::*;

  int   failCount = 0;  // Read by the testbench for its summary.
  logic heldSquashed;

  // The packet at the output is hit when the resolved checkpoint is in its mask.
  assign heldSquashed = branch_i.valid && branch_i.mispredict &&
                        execPacket_o.inst.branchMask[branch_i.ckptId];

  resetValues: assert property (@(posedge clk)
    !arstN_i |-> (!execValid_o && issueReady_o))
    else begin
      failCount++;
      $error("execValid_o or issueReady_o is not at its reset value during reset");
    end

  // A stalled packet stays put, or it goes away because it was squashed.
  stallStable: assert property (@(posedge clk) disable iff (!arstN_i)
    (execValid_o && !execReady_i) |=>
      ((execValid_o && $stable(execPacket_o)) || (!execValid_o && heldSquashed)))
    else begin
      failCount++;
      $error("stalled output packet changed or dropped without a squash");
    end

  readyKnown: assert property (@(posedge clk) !$isunknown(phyRegRdy_o))
    else begin
      failCount++;
      $error("phyRegRdy_o holds unknown bits");
    end

endmodule

bind regReadStage regReadProps u_props (.*);

//--- verification/regReadTb.sv
/*
 * Testbench for the register-read stage.
 * Directed and random tests with in-order output checking, watchdog and summary.
 */

`timescale 1ns/1ps

module regReadTb;

  import rrPkg::*;

  localparam int TEST_CYCLES = 200;  // Generous estimate of all tests together.
  localparam int WAIT_LIMIT  = 50;

  logic                     clk = 1'b0;
  logic                     arstN;
  logic                     issueValid;
  issuePacket_t             issuePacket;
  logic                     issueReady;
  wbPort_t                  wbPorts    [NUM_WB_PORTS];
  unmapPort_t               unmapPorts [NUM_WB_PORTS];
  branchResolve_t           branch;
  logic                     recover;
  logic                     exception;
  logic                     execValid;
  readPacket_t              execPacket;
  logic                     execReady;
  logic [NUM_PHYS_REGS-1:0] phyRegRdy;

  regData_t    shadow [NUM_PHYS_REGS];  // Values the file should hold.
  readPacket_t expQ [$];                // Packets still owed by the stage, oldest first.
  string       testName = "reset";
  int unsigned salt;
  int          testErrors;
  int          testsPassed = 0;
  int          testsFailed = 0;
  int          propFails;

  always #50 clk = ~clk;

  regReadStage u_dut (
    .clk          (clk),
    .arstN_i      (arstN),
    .issueValid_i (issueValid),
    .issuePacket_i(issuePacket),
    .issueReady_o (issueReady),
    .wbPorts_i    (wbPorts),
    .unmapPorts_i (unmapPorts),
    .branch_i     (branch),
    .recover_i    (recover),
    .exception_i  (exception),
    .execValid_o  (execValid),
    .execPacket_o (execPacket),
    .execReady_i  (execReady),
    .phyRegRdy_o  (phyRegRdy)
  );

  // ==========================================================================
  // Helpers
  // ==========================================================================

  function automatic regData_t tagValue(input int tag, input int unsigned s);
    return (regData_t'(tag) * 32'h01010101) ^ s;
  endfunction

  function automatic logic [NUM_PHYS_REGS-1:0] archReady();
    logic [NUM_PHYS_REGS-1:0] v;
    v = '0;
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
      v[i] = 1'b1;
    end
    return v;
  endfunction

  function automatic issuePacket_t randomPacket(input branchMask_t mask);
    issuePacket_t pkt;
    pkt.branchMask = mask;
    pkt.src1Tag    = physTag_t'($urandom);
    pkt.src2Tag    = physTag_t'($urandom);
    pkt.payload    = PAYLOAD_W'({$urandom, $urandom});
    return pkt;
  endfunction

  function automatic readPacket_t expectFromFile(input issuePacket_t pkt);
    readPacket_t exp;
    exp.inst     = pkt;
    exp.src1Data = shadow[pkt.src1Tag];
    exp.src2Data = shadow[pkt.src2Tag];
    return exp;
  endfunction

  task automatic reportMismatch(input logic [131:0] expected, input logic [131:0] actual);
    $display("Fail %s: expected %0h, actual %0h", testName, expected, actual);
    testErrors++;
  endtask

  task automatic reportProblem(input string what);
    $display("Error in %s: %s", testName, what);
    testErrors++;
  endtask

  task automatic idleSideband();
    for (int p = 0; p < NUM_WB_PORTS; p++) begin
      wbPorts[p]    = '0;
      unmapPorts[p] = '0;
    end
    branch    = '0;
    recover   = 1'b0;
    exception = 1'b0;
  endtask

  task automatic driveWb(input int port, input physTag_t tag, input regData_t data);
    wbPorts[port] = '{valid: 1'b1, tag: tag, data: data};
  endtask

  task automatic driveUnmap(input int port, input physTag_t tag);
    unmapPorts[port] = '{valid: 1'b1, tag: tag};
  endtask

  task automatic beginTest(input string name);
    testName   = name;
    testErrors = 0;
    salt       = $urandom;
  endtask

  task automatic finishTest();
    if (testErrors == 0) begin
      testsPassed++;
      $display("Test %s passed", testName);
    end else begin
      testsFailed++;
      $display("Test %s failed with %0d errors", testName, testErrors);
    end
  endtask

  // Holds the packet on the issue port until it is taken, then idles the side band.
  task automatic sendPacket(input issuePacket_t pkt);
    int waits;
    waits       = 0;
    issueValid  = 1'b1;
    issuePacket = pkt;
    @(posedge clk);
    while (!issueReady && waits < WAIT_LIMIT) begin
      waits++;
      @(posedge clk);
    end
    if (waits == WAIT_LIMIT) begin
      reportProblem("issue side never became ready");
    end
    @(negedge clk);
    issueValid = 1'b0;
    idleSideband();
  endtask

  task automatic drainOutputs();
    int waits;
    waits = 0;
    while (expQ.size() > 0 && waits < WAIT_LIMIT) begin
      @(negedge clk);
      waits++;
    end
    if (expQ.size() > 0) begin
      reportProblem("expected packets never left the stage");
      expQ.delete();
    end
  endtask

  // Every packet taken by execute must be the oldest one still owed.
  always @(posedge clk) begin
    if (arstN && execValid && execReady) begin
      if (expQ.size() == 0) begin
        reportProblem("a packet left the stage that was not expected");
      end else begin
        assert (execPacket == expQ[0]) else reportMismatch(expQ[0], execPacket);
        void'(expQ.pop_front());
      end
    end
  end

  // ==========================================================================
  // Tests
  // ==========================================================================

  task automatic testRegisterRead();
    issuePacket_t pkt;
    beginTest("registerRead");
    for (int p = 0; p < NUM_PHYS_REGS / 2; p++) begin
      driveWb(0, physTag_t'(p), tagValue(p, salt));
      driveWb(1, physTag_t'(p + NUM_PHYS_REGS / 2), tagValue(p + NUM_PHYS_REGS / 2, salt));
      shadow[p]                     = tagValue(p, salt);
      shadow[p + NUM_PHYS_REGS / 2] = tagValue(p + NUM_PHYS_REGS / 2, salt);
      @(negedge clk);
    end
    idleSideband();
    for (int n = 0; n < 16; n++) begin
      pkt = randomPacket(branchMask_t'($urandom));
      expQ.push_back(expectFromFile(pkt));
      sendPacket(pkt);
    end
    drainOutputs();
    finishTest();
  endtask

  task automatic testBypass();
    issuePacket_t pkt;
    readPacket_t  exp;
    beginTest("bypass");
    pkt         = randomPacket('0);
    pkt.src2Tag = pkt.src1Tag ^ physTag_t'(1);  // One port per source.
    driveWb(0, pkt.src1Tag, tagValue(pkt.src1Tag, salt));
    driveWb(1, pkt.src2Tag, tagValue(pkt.src2Tag, salt));
    exp.inst     = pkt;
    exp.src1Data = tagValue(pkt.src1Tag, salt);
    exp.src2Data = tagValue(pkt.src2Tag, salt);
    shadow[pkt.src1Tag] = exp.src1Data;
    shadow[pkt.src2Tag] = exp.src2Data;
    expQ.push_back(exp);
    sendPacket(pkt);
    pkt         = randomPacket('0);
    pkt.src2Tag = pkt.src1Tag;  // Both ports hit both sources, port 0 must win.
    driveWb(1, pkt.src1Tag, tagValue(pkt.src1Tag, ~salt));
    driveWb(0, pkt.src1Tag, tagValue(pkt.src1Tag, salt));
    exp.inst     = pkt;
    exp.src1Data = tagValue(pkt.src1Tag, salt);
    exp.src2Data = exp.src1Data;
    shadow[pkt.src1Tag] = exp.src1Data;
    expQ.push_back(exp);
    sendPacket(pkt);
    drainOutputs();
    finishTest();
  endtask

  task automatic testRecovery();
    issuePacket_t pkt;
    physTag_t     tag;
    beginTest("recovery");
    tag     = physTag_t'($urandom);
    recover = 1'b1;
    driveWb(0, tag, tagValue(tag, salt));  // Must not reach the file.
    @(negedge clk);
    idleSideband();
    pkt         = randomPacket('0);
    pkt.src1Tag = tag;
    expQ.push_back(expectFromFile(pkt));
    sendPacket(pkt);
    drainOutputs();
    finishTest();
  endtask

  task automatic testSquash();
    issuePacket_t pkt;
    beginTest("squash");
    branch = '{valid: 1'b1, mispredict: 1'b1, ckptId: CKPT_ID_W'(3)};
    sendPacket(randomPacket(8'h08));  // Killed on entry.
    pkt    = randomPacket(8'h04);
    branch = '{valid: 1'b1, mispredict: 1'b1, ckptId: CKPT_ID_W'(3)};
    expQ.push_back(expectFromFile(pkt));
    sendPacket(pkt);
    pkt    = randomPacket(8'h08);
    branch = '{valid: 1'b1, mispredict: 1'b0, ckptId: CKPT_ID_W'(3)};
    expQ.push_back(expectFromFile(pkt));
    sendPacket(pkt);
    drainOutputs();
    // Oldest held packet is killed and the younger one moves up.
    execReady = 1'b0;
    sendPacket(randomPacket(8'h20));
    pkt = randomPacket(8'h01);
    expQ.push_back(expectFromFile(pkt));
    sendPacket(pkt);
    branch = '{valid: 1'b1, mispredict: 1'b1, ckptId: CKPT_ID_W'(5)};
    @(negedge clk);
    idleSideband();
    execReady = 1'b1;
    drainOutputs();
    finishTest();
  endtask

  task automatic testBackPressure();
    issuePacket_t pkt;
    beginTest("backPressure");
    execReady = 1'b0;
    for (int n = 0; n < 2; n++) begin
      pkt = randomPacket(branchMask_t'($urandom));
      expQ.push_back(expectFromFile(pkt));
      sendPacket(pkt);
    end
    assert (issueReady == 1'b0) else reportMismatch(0, issueReady);
    pkt = randomPacket(branchMask_t'($urandom));
    expQ.push_back(expectFromFile(pkt));
    fork
      begin
        repeat (3) @(negedge clk);
        execReady = 1'b1;
      end
      sendPacket(pkt);
    join
    fork
      begin
        repeat (20) begin
          @(negedge clk);
          execReady = 1'($urandom_range(1));
        end
        execReady = 1'b1;
      end
      for (int n = 0; n < 8; n++) begin
        pkt = randomPacket(branchMask_t'($urandom));
        expQ.push_back(expectFromFile(pkt));
        sendPacket(pkt);
      end
    join
    drainOutputs();
    finishTest();
  endtask

  task automatic testScoreboard();
    physTag_t tag;
    beginTest("scoreboard");
    arstN = 1'b0;
    repeat (2) @(negedge clk);
    assert (phyRegRdy == archReady()) else reportMismatch(archReady(), phyRegRdy);
    arstN = 1'b1;
    tag   = physTag_t'(NUM_ARCH_REGS + $urandom_range(NUM_ARCH_REGS - 1));
    driveWb(0, tag, tagValue(tag, salt));
    shadow[tag] = tagValue(tag, salt);
    @(negedge clk);
    idleSideband();
    assert (phyRegRdy[tag] == 1'b1) else reportMismatch(1, phyRegRdy[tag]);
    driveUnmap(1, tag);
    @(negedge clk);
    idleSideband();
    assert (phyRegRdy[tag] == 1'b0) else reportMismatch(0, phyRegRdy[tag]);
    driveUnmap(0, tag);  // The set wins over a clear in the same cycle.
    driveWb(1, tag, tagValue(tag, salt));
    @(negedge clk);
    idleSideband();
    assert (phyRegRdy[tag] == 1'b1) else reportMismatch(1, phyRegRdy[tag]);
    exception = 1'b1;
    @(negedge clk);
    idleSideband();
    assert (phyRegRdy == archReady()) else reportMismatch(archReady(), phyRegRdy);
    finishTest();
  endtask

  // ==========================================================================
  // Main sequence and watchdog
  // ==========================================================================

  initial begin
    void'($urandom(15310));
    arstN       = 1'b0;
    issueValid  = 1'b0;
    issuePacket = '0;
    execReady   = 1'b1;
    idleSideband();
    repeat (5) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    testRegisterRead();
    testBypass();
    testRecovery();
    testSquash();
    testBackPressure();
    testScoreboard();
    propFails = u_dut.u_props.failCount;
    $display("Summary: %0d tests passed, %0d failed, %0d bound assertion failures",
             testsPassed, testsFailed, propFails);
    if (testsFailed == 0 && propFails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 4 * 100);
    $display("Watchdog expired during test %s, the run is stuck", testName);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- compile.f
logic/rrPkg.sv
logic/physRegFile.sv
logic/operandBypass.sv
logic/squashBuffer.sv
logic/readyScoreboard.sv
logic/regReadStage.sv
verification/regRead_props.sv
verification/regReadTb.sv

//--- Bender.yml
package:
  name: reg_read_stage

sources:
  - files:
      - logic/rrPkg.sv
      - logic/physRegFile.sv
      - logic/operandBypass.sv
      - logic/squashBuffer.sv
      - logic/readyScoreboard.sv
      - logic/regReadStage.sv
  - target: test
    files:
      - verification/regRead_props.sv
      - verification/regReadTb.sv
